/* hdl/trace_config.svh */
// fixed build-time sizes and byte register offsets; accesses are assumed word aligned
`ifndef TRACE_CONFIG_SVH
`define TRACE_CONFIG_SVH

// trace window and rule count
`define TRACE_WINDOW_BITS 64
`define TRACE_NUM_RULES   4

// sync frame fragments as seen in the compare word
`define TRACE_SYNC_HEAD   16'h7fff
`define TRACE_SYNC_TAIL   8'hff

// register map
`define REG_CTRL          8'h00
`define REG_STATUS        8'h04
`define REG_ENABLE        8'h08
`define REG_RULE_BASE     8'h10
`define REG_RULE_STRIDE   8'h10
`define REG_COUNT_BASE    8'h50
`define REG_MATCHED_LO    8'h60
`define REG_MATCHED_HI    8'h64

`endif

/* hdl/trace_pkg.sv */
// vector types for the trace front end; widths come from the config header
`include "trace_config.svh"

package trace_pkg;

   // window as shifted in, or its reversed compare view
   typedef logic [`TRACE_WINDOW_BITS-1:0] trace_word_t;

   // raw port pins
   typedef logic [3:0] trace_nibble_t;

   // width code, only 1, 2 and 4 are meaningful
   typedef logic [2:0] trace_width_t;

   // one bit per match rule
   typedef logic [`TRACE_NUM_RULES-1:0] rule_mask_t;

   // per-rule hit counter, wraps
   typedef logic [7:0] hit_count_t;

   // register bus
   typedef logic [7:0]  axil_addr_t;
   typedef logic [31:0] axil_data_t;

endpackage

/* hdl/trace_axil_regs.sv */
// axi4-lite slave with one transaction in flight per direction; word-aligned addresses, unmapped reads return 0
`include "trace_config.svh"

module trace_axil_regs import trace_pkg::*; (
   input  logic                                trace_clk,
   input  logic                                reset,
   // write address and data
   input  axil_addr_t                          awaddr,
   input  logic                                awvalid,
   output logic                                awready,
   input  axil_data_t                          wdata,
   input  logic [3:0]                          wstrb,
   input  logic                                wvalid,
   output logic                                wready,
   // write response
   output logic [1:0]                          bresp,
   output logic                                bvalid,
   input  logic                                bready,
   // read channels
   input  axil_addr_t                          araddr,
   input  logic                                arvalid,
   output logic                                arready,
   output axil_data_t                          rdata,
   output logic [1:0]                          rresp,
   output logic                                rvalid,
   input  logic                                rready,
   // configuration out
   output trace_width_t                        trace_width,
   output logic                                resync_req,
   output logic                                arm,
   output rule_mask_t                          rule_enable,
   output rule_mask_t                          trig_enable,
   output trace_word_t [`TRACE_NUM_RULES-1:0]  patterns,
   output trace_word_t [`TRACE_NUM_RULES-1:0]  masks,
   // status in
   input  logic                                synchronized,
   input  hit_count_t [`TRACE_NUM_RULES-1:0]   hit_counts,
   input  trace_word_t                         matched_word
);

   logic       wr_fire;
   logic       rd_fire;
   axil_data_t rd_word;

   // byte-lane merge for partial writes
   function automatic axil_data_t apply_strobe(axil_data_t old_word, axil_data_t new_word,
                                               logic [3:0] strb);
      axil_data_t merged;
      merged = old_word;
      for (int b = 0; b < 4; b++) begin
         if (strb[b])
            merged[8*b +: 8] = new_word[8*b +: 8];
      end
      return merged;
   endfunction

   ////////////////////////////////////////////////////////////
   // handshakes
   ////////////////////////////////////////////////////////////

   // always OKAY
   assign bresp = 2'b00;
   assign rresp = 2'b00;

   assign wr_fire = awready && awvalid && wvalid;
   assign rd_fire = arready && arvalid;

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         awready <= 1'b0;
         wready  <= 1'b0;
         bvalid  <= 1'b0;
         arready <= 1'b0;
         rvalid  <= 1'b0;
      end else begin
         // single-cycle ready, blocked by a pending response
         awready <= awvalid && wvalid && !bvalid && !awready;
         wready  <= awvalid && wvalid && !bvalid && !awready;
         if (wr_fire)
            bvalid <= 1'b1;
         else if (bready)
            bvalid <= 1'b0;
         arready <= arvalid && !rvalid && !arready;
         if (rd_fire)
            rvalid <= 1'b1;
         else if (rready)
            rvalid <= 1'b0;
      end
   end

   // read data captured with the address
   always_ff @(posedge trace_clk) begin
      if (rd_fire)
         rdata <= rd_word;
   end

   ////////////////////////////////////////////////////////////
   // configuration registers
   ////////////////////////////////////////////////////////////

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         trace_width <= 3'd4;
         arm         <= 1'b0;
         resync_req  <= 1'b0;
         rule_enable <= '0;
         trig_enable <= '0;
         patterns    <= '0;
         masks       <= '0;
      end else begin
         // pulse only on the write cycle
         resync_req <= wr_fire && (awaddr == `REG_CTRL) && wstrb[1] && wdata[8];
         if (wr_fire) begin
            if (awaddr == `REG_CTRL && wstrb[0]) begin
               trace_width <= wdata[2:0];
               arm         <= wdata[4];
            end
            if (awaddr == `REG_ENABLE) begin
               if (wstrb[0])
                  rule_enable <= wdata[`TRACE_NUM_RULES-1:0];
               if (wstrb[1])
                  trig_enable <= wdata[8 +: `TRACE_NUM_RULES];
            end
            // rule block: pattern lo/hi then mask lo/hi
            for (int r = 0; r < `TRACE_NUM_RULES; r++) begin
               if (awaddr == axil_addr_t'(`REG_RULE_BASE + `REG_RULE_STRIDE*r))
                  patterns[r][31:0] <= apply_strobe(patterns[r][31:0], wdata, wstrb);
               if (awaddr == axil_addr_t'(`REG_RULE_BASE + `REG_RULE_STRIDE*r + 4))
                  patterns[r][63:32] <= apply_strobe(patterns[r][63:32], wdata, wstrb);
               if (awaddr == axil_addr_t'(`REG_RULE_BASE + `REG_RULE_STRIDE*r + 8))
                  masks[r][31:0] <= apply_strobe(masks[r][31:0], wdata, wstrb);
               if (awaddr == axil_addr_t'(`REG_RULE_BASE + `REG_RULE_STRIDE*r + 12))
                  masks[r][63:32] <= apply_strobe(masks[r][63:32], wdata, wstrb);
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // read mux
   ////////////////////////////////////////////////////////////

   always_comb begin
      rd_word = '0;
      case (araddr)
         // resync bit always reads back 0
         `REG_CTRL:       rd_word = {27'd0, arm, 1'b0, trace_width};
         `REG_STATUS:     rd_word = {31'd0, synchronized};
         `REG_ENABLE: begin
            rd_word[`TRACE_NUM_RULES-1:0] = rule_enable;
            rd_word[8 +: `TRACE_NUM_RULES] = trig_enable;
         end
         `REG_MATCHED_LO: rd_word = matched_word[31:0];
         `REG_MATCHED_HI: rd_word = matched_word[63:32];
         default: begin
            for (int r = 0; r < `TRACE_NUM_RULES; r++) begin
               if (araddr == axil_addr_t'(`REG_RULE_BASE + `REG_RULE_STRIDE*r))
                  rd_word = patterns[r][31:0];
               if (araddr == axil_addr_t'(`REG_RULE_BASE + `REG_RULE_STRIDE*r + 4))
                  rd_word = patterns[r][63:32];
               if (araddr == axil_addr_t'(`REG_RULE_BASE + `REG_RULE_STRIDE*r + 8))
                  rd_word = masks[r][31:0];
               if (araddr == axil_addr_t'(`REG_RULE_BASE + `REG_RULE_STRIDE*r + 12))
                  rd_word = masks[r][63:32];
               if (araddr == axil_addr_t'(`REG_COUNT_BASE + 4*r))
                  rd_word = {24'd0, hit_counts[r]};
            end
         end
      endcase
   end

   // a response only ever follows an accepted write
   assert property (@(posedge trace_clk) disable iff (reset)
      $rose(bvalid) |-> $past(wr_fire));

   // read data held steady under back-pressure
   assert property (@(posedge trace_clk) disable iff (reset)
      rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

/* hdl/trace_deserializer.sv */
// parallel port only; width codes other than 1, 2, 4 fall back to one bit per cycle
`include "trace_config.svh"

module trace_deserializer import trace_pkg::*; (
   input  logic          trace_clk,
   input  logic          reset,
   input  trace_nibble_t trace_data,
   input  trace_width_t  trace_width,
   output trace_word_t   compare_word
);

   localparam int win = `TRACE_WINDOW_BITS;

   // newest bit lands in bit 0
   trace_word_t shift_q;

   ////////////////////////////////////////////////////////////
   // shift in arrival order
   ////////////////////////////////////////////////////////////

   // pin 0 is earliest in time so it goes in first
   always_ff @(posedge trace_clk) begin
      if (reset) begin
         shift_q <= '0;
      end else begin
         case (trace_width)
            3'd4:
               shift_q <= {shift_q[win-5:0], trace_data[0], trace_data[1],
                           trace_data[2], trace_data[3]};
            3'd2:
               shift_q <= {shift_q[win-3:0], trace_data[0], trace_data[1]};
            default:
               shift_q <= {shift_q[win-2:0], trace_data[0]};
         endcase
      end
   end

   // reversed view, newest bit ends up at the top
   always_comb begin
      for (int i = 0; i < win; i++) begin
         compare_word[i] = shift_q[win-1-i];
      end
   end

endmodule

/* hdl/sync_tracker.sv */
// lock is by head/tail sync fragments only; a width change or resync request drops it
`include "trace_config.svh"

module sync_tracker import trace_pkg::*; (
   input  logic         trace_clk,
   input  logic         reset,
   input  trace_word_t  compare_word,
   input  trace_width_t trace_width,
   input  logic         resync_req,
   output logic         synchronized,
   output logic         valid_window
);

   logic         sync_seen;
   logic [2:0]   phase;
   trace_width_t width_q;

   // full or half sync frame sitting in the window
   assign sync_seen = (compare_word[`TRACE_WINDOW_BITS-1 -: 16] == `TRACE_SYNC_HEAD) &&
                      (compare_word[7:0] == `TRACE_SYNC_TAIL);

   ////////////////////////////////////////////////////////////
   // lock state and byte phase
   ////////////////////////////////////////////////////////////

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         synchronized <= 1'b0;
         phase        <= '0;
         width_q      <= '0;
      end else begin
         width_q <= trace_width;
         if (resync_req || (trace_width != width_q)) begin
            // drop lock, wait for fresh sync frames
            synchronized <= 1'b0;
            phase        <= '0;
         end else if (!synchronized && sync_seen) begin
            synchronized <= 1'b1;
            phase        <= 3'd1;
         end else if (synchronized) begin
            // phase wraps every 8 cycles
            phase <= phase + 3'd1;
         end
      end
   end

   // byte boundary every 8, 4 or 2 cycles
   always_comb begin
      case (trace_width)
         3'd1:    valid_window = synchronized && (phase[2:0] == 3'd0);
         3'd2:    valid_window = synchronized && (phase[1:0] == 2'd0);
         3'd4:    valid_window = synchronized && !phase[0];
         default: valid_window = 1'b0;
      endcase
   end

   // byte windows are at least two cycles apart
   assert property (@(posedge trace_clk) disable iff (reset)
      valid_window |=> !valid_window);

endmodule

/* hdl/pattern_matcher.sv */
// compare happens only on valid windows; counters wrap at 8 bits, last window held until next hit
`include "trace_config.svh"

module pattern_matcher import trace_pkg::*; #(
   parameter int num_rules = `TRACE_NUM_RULES
) (
   input  logic                          trace_clk,
   input  logic                          reset,
   input  trace_word_t                   compare_word,
   input  logic                          valid_window,
   input  logic [num_rules-1:0]          rule_enable,
   input  logic [num_rules-1:0]          trig_enable,
   input  logic                          arm,
   input  trace_word_t [num_rules-1:0]   patterns,
   input  trace_word_t [num_rules-1:0]   masks,
   output hit_count_t [num_rules-1:0]    hit_counts,
   output trace_word_t                   matched_word,
   output logic                          match_event,
   output logic                          trigger_match
);

   logic [num_rules-1:0] rule_hit;
   logic [num_rules-1:0] trig_hit;
   logic [num_rules-1:0] trig_hit_q;

   ////////////////////////////////////////////////////////////
   // masked compare
   ////////////////////////////////////////////////////////////

   // only mask bits take part
   always_comb begin
      for (int r = 0; r < num_rules; r++) begin
         rule_hit[r] = rule_enable[r] && valid_window &&
                       ((compare_word & masks[r]) == (patterns[r] & masks[r]));
      end
   end

   assign match_event = |rule_hit;
   assign trig_hit    = rule_hit & trig_enable;

   ////////////////////////////////////////////////////////////
   // counters and capture
   ////////////////////////////////////////////////////////////

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         hit_counts   <= '0;
         matched_word <= '0;
      end else begin
         for (int r = 0; r < num_rules; r++) begin
            if (rule_hit[r])
               hit_counts[r] <= hit_counts[r] + 8'd1;
         end
         // any rule, same window for all
         if (match_event)
            matched_word <= compare_word;
      end
   end

   // rising edge of trigger-enabled hits
   always_ff @(posedge trace_clk) begin
      if (reset) begin
         trig_hit_q    <= '0;
         trigger_match <= 1'b0;
      end else begin
         trig_hit_q    <= trig_hit;
         trigger_match <= arm && (|trig_hit) && !(|trig_hit_q);
      end
   end

   // back-to-back hits give one pulse only
   assert property (@(posedge trace_clk) disable iff (reset)
      trigger_match |=> !trigger_match);

endmodule

/* hdl/trace_top.sv */
// single trace_clk domain, parallel trace port only, register access over axi4-lite
`include "trace_config.svh"

module trace_top import trace_pkg::*; (
   input  logic          trace_clk,
   input  logic          reset,
   input  trace_nibble_t trace_data,
   // axi4-lite slave
   input  axil_addr_t    awaddr,
   input  logic          awvalid,
   output logic          awready,
   input  axil_data_t    wdata,
   input  logic [3:0]    wstrb,
   input  logic          wvalid,
   output logic          wready,
   output logic [1:0]    bresp,
   output logic          bvalid,
   input  logic          bready,
   input  axil_addr_t    araddr,
   input  logic          arvalid,
   output logic          arready,
   output axil_data_t    rdata,
   output logic [1:0]    rresp,
   output logic          rvalid,
   input  logic          rready,
   // match outputs
   output logic          match_event,
   output logic          trigger_match
);

   trace_width_t                        trace_width;
   logic                                resync_req;
   logic                                arm;
   rule_mask_t                          rule_enable;
   rule_mask_t                          trig_enable;
   trace_word_t [`TRACE_NUM_RULES-1:0]  patterns;
   trace_word_t [`TRACE_NUM_RULES-1:0]  masks;
   hit_count_t  [`TRACE_NUM_RULES-1:0]  hit_counts;
   trace_word_t                         matched_word;
   trace_word_t                         compare_word;
   logic                                synchronized;
   logic                                valid_window;

   ////////////////////////////////////////////////////////////
   // register block
   ////////////////////////////////////////////////////////////

   trace_axil_regs u_regs (
      .trace_clk    (trace_clk),
      .reset        (reset),
      .awaddr       (awaddr),
      .awvalid      (awvalid),
      .awready      (awready),
      .wdata        (wdata),
      .wstrb        (wstrb),
      .wvalid       (wvalid),
      .wready       (wready),
      .bresp        (bresp),
      .bvalid       (bvalid),
      .bready       (bready),
      .araddr       (araddr),
      .arvalid      (arvalid),
      .arready      (arready),
      .rdata        (rdata),
      .rresp        (rresp),
      .rvalid       (rvalid),
      .rready       (rready),
      .trace_width  (trace_width),
      .resync_req   (resync_req),
      .arm          (arm),
      .rule_enable  (rule_enable),
      .trig_enable  (trig_enable),
      .patterns     (patterns),
      .masks        (masks),
      .synchronized (synchronized),
      .hit_counts   (hit_counts),
      .matched_word (matched_word)
   );

   ////////////////////////////////////////////////////////////
   // trace path
   ////////////////////////////////////////////////////////////

   trace_deserializer u_deser (
      .trace_clk    (trace_clk),
      .reset        (reset),
      .trace_data   (trace_data),
      .trace_width  (trace_width),
      .compare_word (compare_word)
   );

   sync_tracker u_sync (
      .trace_clk    (trace_clk),
      .reset        (reset),
      .compare_word (compare_word),
      .trace_width  (trace_width),
      .resync_req   (resync_req),
      .synchronized (synchronized),
      .valid_window (valid_window)
   );

   pattern_matcher #(
      .num_rules    (`TRACE_NUM_RULES)
   ) u_match (
      .trace_clk     (trace_clk),
      .reset         (reset),
      .compare_word  (compare_word),
      .valid_window  (valid_window),
      .rule_enable   (rule_enable),
      .trig_enable   (trig_enable),
      .arm           (arm),
      .patterns      (patterns),
      .masks         (masks),
      .hit_counts    (hit_counts),
      .matched_word  (matched_word),
      .match_event   (match_event),
      .trigger_match (trigger_match)
   );

endmodule

/* test/trace_tb.sv */
// the model follows the trace path only while config is steady; config is written with the port idle
`include "trace_config.svh"

module trace_tb import trace_pkg::*; ();

   logic          trace_clk;
   logic          reset;
   trace_nibble_t trace_data;
   axil_addr_t    awaddr;
   logic          awvalid;
   logic          awready;
   axil_data_t    wdata;
   logic [3:0]    wstrb;
   logic          wvalid;
   logic          wready;
   logic [1:0]    bresp;
   logic          bvalid;
   logic          bready;
   axil_addr_t    araddr;
   logic          arvalid;
   logic          arready;
   axil_data_t    rdata;
   logic [1:0]    rresp;
   logic          rvalid;
   logic          rready;
   logic          match_event;
   logic          trigger_match;

   // reference state
   trace_word_t   m_hist;
   trace_word_t   m_cw;
   trace_word_t   m_last;
   logic          m_sync;
   logic [2:0]    m_phase;
   trace_width_t  m_width;
   logic          m_trig_prev;
   logic          model_on;
   rule_mask_t    step_hits;
   int            m_count [`TRACE_NUM_RULES];
   int            exp_trig;
   int            got_trig;
   int            errors;
   int            prev_trig;

   // mirror of what was written to the DUT
   trace_word_t   cfg_pat  [`TRACE_NUM_RULES];
   trace_word_t   cfg_mask [`TRACE_NUM_RULES];
   rule_mask_t    cfg_en;
   rule_mask_t    cfg_trig;
   logic          cfg_arm;

   trace_top DUT (.*);

   initial begin
      trace_clk = 1'b0;
      forever #4 trace_clk = ~trace_clk;
   end

   ////////////////////////////////////////////////////////////
   // reference model, one call per clock edge
   ////////////////////////////////////////////////////////////

   function automatic rule_mask_t model_step(input trace_nibble_t d);
      rule_mask_t hits;
      logic       valid;
      int         n;
      // newest bit goes to the top of the compare view
      for (int i = 0; i < `TRACE_WINDOW_BITS; i++)
         m_cw[i] = m_hist[`TRACE_WINDOW_BITS-1-i];
      // bits per clock; any other code moves one bit and never frames a byte
      n = (m_width == 3'd2 || m_width == 3'd4) ? int'(m_width) : 1;
      // byte boundary when the bits since lock are a multiple of 8
      valid = m_sync && (n > 1 || m_width == 3'd1) && ((int'(m_phase) * n) % 8 == 0);
      for (int r = 0; r < `TRACE_NUM_RULES; r++)
         hits[r] = cfg_en[r] && valid && (((m_cw ^ cfg_pat[r]) & cfg_mask[r]) == '0);
      if (!m_sync && m_cw[63:48] == `TRACE_SYNC_HEAD && m_cw[7:0] == `TRACE_SYNC_TAIL) begin
         m_sync  = 1'b1;
         m_phase = 3'd1;
      end else if (m_sync) begin
         m_phase = m_phase + 3'd1;
      end
      // pin 0 earliest in time
      for (int i = 0; i < n; i++)
         m_hist = {m_hist[`TRACE_WINDOW_BITS-2:0], d[i]};
      return hits;
   endfunction

   // compare process samples pre-edge values at every rising edge
   always @(posedge trace_clk) begin
      if (trigger_match === 1'b1)
         got_trig++;
      if (model_on) begin
         step_hits = model_step(trace_data);
         if (match_event !== (|step_hits)) begin
            errors++;
            $display("Mismatch match_event: got %h expected %h", match_event, |step_hits);
         end
         for (int r = 0; r < `TRACE_NUM_RULES; r++)
            if (step_hits[r])
               m_count[r]++;
         if (|step_hits)
            m_last = m_cw;
         if (cfg_arm && |(step_hits & cfg_trig) && !m_trig_prev)
            exp_trig++;
         m_trig_prev = |(step_hits & cfg_trig);
      end
   end

   ////////////////////////////////////////////////////////////
   // axi4-lite host
   ////////////////////////////////////////////////////////////

   task automatic abort_run(input string what);
      $display("timeout while waiting for %s", what);
      $display("errors: %0d", errors);
      $display("STATUS: FAIL");
      $finish;
   endtask

   task automatic reg_write(input axil_addr_t a, input axil_data_t d, input int hold);
      int t;
      @(negedge trace_clk);
      awaddr  = a;
      wdata   = d;
      wstrb   = 4'hf;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      t = 0;
      do begin
         @(posedge trace_clk);
         t++;
         if (t > 50)
            abort_run("awready");
      end while (!awready);
      // both ready lines rise in the same cycle
      if (wready !== 1'b1) begin
         errors++;
         $display("Mismatch wready: got %h expected %h", wready, 1'b1);
      end
      @(negedge trace_clk);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      t = 0;
      while (!bvalid) begin
         @(negedge trace_clk);
         t++;
         if (t > 50)
            abort_run("bvalid");
      end
      if (bresp !== 2'b00) begin
         errors++;
         $display("Mismatch bresp: got %h expected %h", bresp, 2'b00);
      end
      // response must wait for bready
      repeat (hold) begin
         @(negedge trace_clk);
         if (!bvalid) begin
            errors++;
            $display("bvalid dropped before bready was given");
         end
      end
      bready = 1'b1;
      @(negedge trace_clk);
      bready = 1'b0;
   endtask

   task automatic reg_read(input axil_addr_t a, output axil_data_t d, input int hold);
      int t;
      @(negedge trace_clk);
      araddr  = a;
      arvalid = 1'b1;
      t = 0;
      do begin
         @(posedge trace_clk);
         t++;
         if (t > 50)
            abort_run("arready");
      end while (!arready);
      @(negedge trace_clk);
      arvalid = 1'b0;
      t = 0;
      while (!rvalid) begin
         @(negedge trace_clk);
         t++;
         if (t > 50)
            abort_run("rvalid");
      end
      if (rresp !== 2'b00) begin
         errors++;
         $display("Mismatch rresp: got %h expected %h", rresp, 2'b00);
      end
      d = rdata;
      repeat (hold) begin
         @(negedge trace_clk);
         if (!rvalid || rdata !== d) begin
            errors++;
            $display("read data was not held until rready");
         end
      end
      rready = 1'b1;
      @(negedge trace_clk);
      rready = 1'b0;
   endtask

   task automatic check_reg(input axil_addr_t a, input axil_data_t exp, input string name,
                            input int hold);
      axil_data_t d;
      reg_read(a, d, hold);
      if (d !== exp) begin
         errors++;
         $display("Mismatch %s: got %h expected %h", name, d, exp);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // trace bit-stream driver
   ////////////////////////////////////////////////////////////

   // lsb of each byte first
   task automatic send_byte(input logic [7:0] b, input int w);
      for (int i = 0; i < 8 / w; i++) begin
         @(negedge trace_clk);
         trace_data = trace_nibble_t'((b >> (i * w)) & ((1 << w) - 1));
      end
   endtask

   task automatic send_word(input trace_word_t p, input int w);
      for (int k = 0; k < 8; k++)
         send_byte(p[8*k +: 8], w);
   endtask

   task automatic idle_port(input int n);
      repeat (n) begin
         @(negedge trace_clk);
         trace_data = '0;
      end
   endtask

   // resync, idle, lock on sync frames, then random bytes with planted rule patterns
   task automatic run_session(input int w, input logic arm_bit, input int nbytes);
      cfg_arm = arm_bit;
      reg_write(`REG_CTRL, 32'h100 | (axil_data_t'(arm_bit) << 4) | axil_data_t'(w), 0);
      idle_port(70);
      check_reg(`REG_STATUS, 32'h0, "status before sync", 0);
      m_hist      = '0;
      m_sync      = 1'b0;
      m_phase     = '0;
      m_width     = trace_width_t'(w);
      m_trig_prev = 1'b0;
      model_on    = 1'b1;
      repeat (2)
         send_word(64'h7fffffff_7fffffff, w);
      for (int k = 0; k < nbytes; k++) begin
         if (k % 16 == 15)
            send_word(cfg_pat[$urandom_range(`TRACE_NUM_RULES-1, 0)], w);
         else
            send_byte(8'($urandom), w);
      end
      // long enough for the last trigger pulse and for the top byte to clear
      idle_port(20);
      model_on = 1'b0;
      check_reg(`REG_STATUS, 32'h1, "status after sync", 0);
   endtask

   ////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////

   initial begin
      void'($urandom(96106));
      reset = 1'b1;
      trace_data = '0;
      awaddr = '0;
      awvalid = 1'b0;
      wdata = '0;
      wstrb = '0;
      wvalid = 1'b0;
      bready = 1'b0;
      araddr = '0;
      arvalid = 1'b0;
      rready = 1'b0;
      model_on = 1'b0;
      errors = 0;
      exp_trig = 0;
      got_trig = 0;
      m_last = '0;
      for (int r = 0; r < `TRACE_NUM_RULES; r++)
         m_count[r] = 0;
      // every pattern keeps a nonzero, non-sync top byte under its mask
      cfg_pat[0]  = 64'hc311_2233_4455_6677;
      cfg_mask[0] = 64'hffff_ffff_ffff_ffff;
      cfg_pat[1]  = 64'h9a00_0000_0000_beef;
      cfg_mask[1] = 64'hff00_0000_0000_ffff;
      cfg_pat[2]  = 64'h5a5a_0000_0000_0000;
      cfg_mask[2] = 64'hffff_0000_0000_0000;
      cfg_pat[3]  = 64'ha500_0000_0000_0000;
      cfg_mask[3] = 64'hff00_0000_0000_0000;
      cfg_en = 4'hf;
      cfg_trig = 4'h5;
      cfg_arm = 1'b1;
      repeat (8) @(posedge trace_clk);
      @(negedge trace_clk);
      reset = 1'b0;

      // register access
      for (int r = 0; r < `TRACE_NUM_RULES; r++) begin
         reg_write(axil_addr_t'(`REG_RULE_BASE + 16*r), cfg_pat[r][31:0], (r == 0) ? 3 : 0);
         reg_write(axil_addr_t'(`REG_RULE_BASE + 16*r + 4), cfg_pat[r][63:32], 0);
         reg_write(axil_addr_t'(`REG_RULE_BASE + 16*r + 8), cfg_mask[r][31:0], 0);
         reg_write(axil_addr_t'(`REG_RULE_BASE + 16*r + 12), cfg_mask[r][63:32], 0);
      end
      reg_write(`REG_ENABLE, 32'h50f, 0);
      reg_write(`REG_CTRL, 32'h14, 2);
      for (int r = 0; r < `TRACE_NUM_RULES; r++) begin
         check_reg(axil_addr_t'(`REG_RULE_BASE + 16*r), cfg_pat[r][31:0], "pattern lo",
                   (r == 1) ? 3 : 0);
         check_reg(axil_addr_t'(`REG_RULE_BASE + 16*r + 4), cfg_pat[r][63:32], "pattern hi", 0);
         check_reg(axil_addr_t'(`REG_RULE_BASE + 16*r + 8), cfg_mask[r][31:0], "mask lo", 0);
         check_reg(axil_addr_t'(`REG_RULE_BASE + 16*r + 12), cfg_mask[r][63:32], "mask hi", 0);
      end
      check_reg(`REG_ENABLE, 32'h50f, "enable", 0);
      check_reg(`REG_CTRL, 32'h14, "ctrl", 2);
      check_reg(8'h0c, 32'h0, "unmapped 0x0c", 0);
      check_reg(8'h70, 32'h0, "unmapped 0x70", 0);

      // lock at every width
      run_session(1, 1'b1, 120);
      run_session(2, 1'b1, 160);
      run_session(4, 1'b1, 200);

      // explicit resync, then a width change
      reg_write(`REG_CTRL, 32'h114, 0);
      idle_port(10);
      check_reg(`REG_STATUS, 32'h0, "status after resync", 0);
      run_session(4, 1'b1, 100);
      reg_write(`REG_CTRL, 32'h12, 0);
      idle_port(10);
      check_reg(`REG_STATUS, 32'h0, "status after width change", 0);
      run_session(2, 1'b1, 100);

      // disarmed
      prev_trig = got_trig;
      run_session(4, 1'b0, 150);
      if (got_trig != prev_trig) begin
         errors++;
         $display("trigger_match pulsed while arm was clear");
      end

      // counters, last window, trigger total
      for (int r = 0; r < `TRACE_NUM_RULES; r++)
         check_reg(axil_addr_t'(`REG_COUNT_BASE + 4*r), m_count[r] & 32'hff, "hit count", 0);
      check_reg(`REG_MATCHED_LO, m_last[31:0], "matched lo", 0);
      check_reg(`REG_MATCHED_HI, m_last[63:32], "matched hi", 0);
      if (got_trig != exp_trig) begin
         errors++;
         $display("Mismatch trigger_match count: got %h expected %h", got_trig, exp_trig);
      end

      $display("done: %0d errors, %0d trigger pulses", errors, got_trig);
      if (errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

/* sim.f */
+incdir+hdl
hdl/trace_pkg.sv
hdl/trace_axil_regs.sv
hdl/trace_deserializer.sv
hdl/sync_tracker.sv
hdl/pattern_matcher.sv
hdl/trace_top.sv
test/trace_tb.sv
